// ==== hdl/fdc_reg_pkg.sv ====
`default_nettype none

package fdc_reg_pkg;

	// host register index on paddr
	typedef enum logic [1:0] {
		REG_CMD    = 2'd0, // command on write, status on read
		REG_TRACK  = 2'd1,
		REG_SECTOR = 2'd2,
		REG_DATA   = 2'd3
	} reg_addr_e;

	// upper nibble of the command byte
	typedef enum logic [3:0] {
		OP_RESTORE      = 4'h0,
		OP_SEEK         = 4'h1,
		OP_STEP         = 4'h2,
		OP_STEP_UPD     = 4'h3,
		OP_STEP_IN      = 4'h4,
		OP_STEP_IN_UPD  = 4'h5,
		OP_STEP_OUT     = 4'h6,
		OP_STEP_OUT_UPD = 4'h7,
		OP_READ_SECTOR  = 4'h8, // single sector
		OP_READ_MULTI   = 4'h9, // until end of track
		OP_WRITE_SECTOR = 4'hA,
		OP_WRITE_MULTI  = 4'hB,
		OP_READ_ADDR    = 4'hC,
		OP_FORCE_INT    = 4'hD,
		OP_READ_TRACK   = 4'hE,
		OP_WRITE_TRACK  = 4'hF
	} fdc_opcode_e;

	// status bits; index is type I only, drq is type II only
	localparam int unsigned STAT_BUSY     = 0;
	localparam int unsigned STAT_DRQ      = 1;
	localparam int unsigned STAT_INDEX    = 1;
	localparam int unsigned STAT_TRACK0   = 2;
	localparam int unsigned STAT_HEADLOAD = 5;
	localparam logic [7:0]  STAT_NOTFOUND = 8'h10;

	typedef enum logic [1:0] {HEAD_IDLE, HEAD_RESTORE, HEAD_SEEK, HEAD_STEP} head_op_e;

	typedef struct packed {
		head_op_e   op;
		logic       dir_valid; // step command carries its own direction
		logic       dir;       // 1 = outward, towards track 0
		logic [7:0] target;    // seek destination
	} head_cmd_t;

endpackage

`default_nettype wire

// ==== hdl/fdc_media_pkg.sv ====
`default_nettype none

package fdc_media_pkg;

	// emulated disk geometry, sectors counted from 1
	localparam int unsigned SECTOR_SIZE       = 512;
	localparam int unsigned SECTORS_PER_TRACK = 10;

	// sector buffer address width
	localparam int unsigned BUF_AW = 9;

	// read request towards the workhorse, held until done
	typedef struct packed {
		logic       valid;
		logic       side;
		logic [7:0] track;
		logic [7:0] sector;
	} media_req_t;

	// workhorse answer, done is a single cycle pulse
	typedef struct packed {
		logic done;
		logic ok; // sector found and copied
	} media_rsp_t;

	// workhorse write port into the sector buffer
	typedef struct packed {
		logic              we;
		logic [BUF_AW-1:0] addr;
		logic [7:0]        data;
	} buf_fill_t;

endpackage

`default_nettype wire

// ==== hdl/head_positioner.sv ====
`timescale 1ns/10ps
`default_nettype none

module head_positioner (
	input wire logic clk,
	input wire logic reset_n,
	input var fdc_reg_pkg::head_cmd_t head_cmd,
	output logic [7:0] position,
	output logic track0
);
	import fdc_reg_pkg::*;

	logic dir_q;    // remembered step direction, 1 = outward
	logic step_dir;
	logic [7:0] next_pos;

	// plain step reuses the last direction given
	assign step_dir = head_cmd.dir_valid ? head_cmd.dir : dir_q;

	always_comb begin
		case (head_cmd.op)
			HEAD_RESTORE: next_pos = 8'h00;
			HEAD_SEEK: next_pos = head_cmd.target;
			HEAD_STEP: next_pos = step_dir ? position - 8'd1 : position + 8'd1; // wraps
			default: next_pos = position;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			position <= '0;
			track0 <= 1'b1; // head starts at track 0
			dir_q <= 1'b0;
		end else if (head_cmd.op != HEAD_IDLE) begin
			position <= next_pos;
			track0 <= next_pos == 8'h00;
			if (head_cmd.op == HEAD_STEP)
				dir_q <= step_dir;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sector_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module sector_buffer (
	input wire logic clk,
	input var fdc_media_pkg::buf_fill_t fill,
	input wire logic [fdc_media_pkg::BUF_AW-1:0] rd_addr,
	output logic [7:0] rd_data
);
	import fdc_media_pkg::*;

	logic [7:0] mem [SECTOR_SIZE];

	// workhorse side
	always_ff @(posedge clk) begin
		if (fill.we)
			mem[fill.addr] <= fill.data;
	end

	// core side, data one cycle after address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== hdl/fdc_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module fdc_core (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input var fdc_reg_pkg::reg_addr_e paddr,
	input wire logic [7:0] pwdata,
	output logic [7:0] prdata,
	output logic pready,
	output logic irq,
	output logic drq,
	output fdc_media_pkg::media_req_t media_req,
	input var fdc_media_pkg::media_rsp_t media_rsp,
	output fdc_reg_pkg::head_cmd_t head_cmd,
	input wire logic [7:0] head_position,
	input wire logic head_track0,
	output logic [fdc_media_pkg::BUF_AW-1:0] buf_rd_addr,
	input wire logic [7:0] buf_rd_data
);
	import fdc_reg_pkg::*;
	import fdc_media_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_TYPE1_FIN, S_WAIT_MEDIA, S_DATA_WAIT} state_e;

	state_e state;
	logic [7:0] status;
	logic [7:0] track_reg;
	logic [7:0] sector_reg;
	logic [7:0] cmd_q;          // last accepted command byte
	logic req_valid;
	logic [BUF_AW:0] remaining; // bytes left in the sector
	logic [BUF_AW-1:0] rd_ptr;
	logic busy;
	logic data_rd_slow;
	logic access;
	logic stat_rd;
	logic track_upd;
	fdc_opcode_e opcode;
	fdc_opcode_e cmd_op;
	head_cmd_t head_next;

	assign busy = status[STAT_BUSY];
	assign opcode = fdc_opcode_e'(pwdata[7:4]);
	assign cmd_op = fdc_opcode_e'(cmd_q[7:4]);

	// data read with bytes left needs one wait state for the buffer
	assign data_rd_slow = psel && penable && !pwrite && paddr == REG_DATA && remaining != '0;
	assign pready = psel && penable && (state == S_DATA_WAIT || !data_rd_slow);
	assign access = psel && penable && pready;
	assign stat_rd = access && !pwrite && paddr == REG_CMD;

	// restore lands on track 0 and copies the position like a step with update
	assign track_upd = cmd_op inside {OP_RESTORE, OP_STEP_UPD, OP_STEP_IN_UPD, OP_STEP_OUT_UPD};

	assign media_req = '{valid: req_valid, side: cmd_q[3], track: track_reg, sector: sector_reg};
	assign buf_rd_addr = rd_ptr;

	always_comb begin
		case (paddr)
			REG_CMD: prdata = status;
			REG_TRACK: prdata = track_reg;
			REG_SECTOR: prdata = sector_reg;
			default: prdata = (state == S_DATA_WAIT) ? buf_rd_data : 8'h00; // empty buffer reads 0
		endcase
	end

	// op stays idle unless pwdata carries a type I opcode
	always_comb begin
		head_next = '{op: HEAD_IDLE, dir_valid: 1'b0, dir: 1'b0, target: track_reg};
		case (opcode)
			OP_RESTORE: head_next.op = HEAD_RESTORE;
			OP_SEEK: head_next.op = HEAD_SEEK; // seeks to the track register
			OP_STEP, OP_STEP_UPD: head_next.op = HEAD_STEP;
			OP_STEP_IN, OP_STEP_IN_UPD, OP_STEP_OUT, OP_STEP_OUT_UPD: begin
				head_next.op = HEAD_STEP;
				head_next.dir_valid = 1'b1;
				head_next.dir = pwdata[5];
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= S_IDLE;
			status <= '0;
			track_reg <= '0;
			sector_reg <= '0;
			cmd_q <= '0;
			req_valid <= 1'b0;
			remaining <= '0;
			rd_ptr <= '0;
			irq <= 1'b0;
			drq <= 1'b0;
			head_cmd <= '0;
		end else begin
			if (stat_rd)
				irq <= 1'b0; // status read acknowledges
			case (state)
				S_IDLE: begin
					if (data_rd_slow)
						state <= S_DATA_WAIT; // buffer read in flight
					if (access && pwrite && !busy) begin
						case (paddr)
							REG_TRACK: track_reg <= pwdata;
							REG_SECTOR: sector_reg <= pwdata;
							REG_CMD: begin
								irq <= 1'b0;
								cmd_q <= pwdata;
								if (head_next.op != HEAD_IDLE) begin
									head_cmd <= head_next;
									status <= '0;
									status[STAT_BUSY] <= 1'b1;
									state <= S_TYPE1_FIN;
								end else if (opcode inside {OP_READ_SECTOR, OP_READ_MULTI}) begin
									req_valid <= 1'b1;
									status <= '0;
									status[STAT_BUSY] <= 1'b1;
									state <= S_WAIT_MEDIA;
								end
								// write, address, track and interrupt opcodes do nothing
							end
							default: ;
						endcase
					end
				end
				S_TYPE1_FIN: begin
					if (head_cmd.op != HEAD_IDLE) begin
						head_cmd.op <= HEAD_IDLE; // positioner moves on this edge
					end else begin
						status <= '0;
						status[STAT_HEADLOAD] <= cmd_q[3];
						status[STAT_TRACK0] <= head_track0;
						status[STAT_INDEX] <= 1'b1;
						if (track_upd)
							track_reg <= head_position;
						irq <= 1'b1;
						state <= S_IDLE;
					end
				end
				S_WAIT_MEDIA: begin
					if (media_rsp.done) begin
						req_valid <= 1'b0;
						state <= S_IDLE;
						if (media_rsp.ok) begin
							status[STAT_BUSY] <= 1'b1;
							status[STAT_DRQ] <= 1'b1;
							drq <= 1'b1;
							irq <= 1'b0;
							remaining <= (BUF_AW+1)'(SECTOR_SIZE);
							rd_ptr <= '0;
						end else begin
							status <= STAT_NOTFOUND;
							irq <= 1'b1;
							drq <= 1'b0;
						end
					end
				end
				S_DATA_WAIT: begin
					if (access) begin
						rd_ptr <= rd_ptr + BUF_AW'(1);
						remaining <= remaining - (BUF_AW+1)'(1);
						state <= S_IDLE;
						if (remaining == (BUF_AW+1)'(1)) begin
							drq <= 1'b0;
							status[STAT_DRQ] <= 1'b0;
							if (cmd_q[4] && sector_reg < 8'(SECTORS_PER_TRACK)) begin
								// multi-sector mode fetches the next one
								sector_reg <= sector_reg + 8'd1;
								req_valid <= 1'b1;
								state <= S_WAIT_MEDIA;
							end else begin
								status[STAT_BUSY] <= 1'b0;
								irq <= 1'b1;
							end
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// workhorse request stays up until it is answered
	a_req_hold: assert property (@(posedge clk) disable iff (!reset_n)
		media_req.valid && !media_rsp.done |=> media_req.valid);

	a_irq_drq: assert property (@(posedge clk) disable iff (!reset_n) !(irq && drq));

	// at most one wait state per access
	a_one_wait: assert property (@(posedge clk) disable iff (!reset_n)
		psel && penable && !pready |=> pready);

endmodule

`default_nettype wire

// ==== hdl/fdc_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fdc_top (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input var fdc_reg_pkg::reg_addr_e paddr,
	input wire logic [7:0] pwdata,
	output logic [7:0] prdata,
	output logic pready,
	output logic irq,
	output logic drq,
	output fdc_media_pkg::media_req_t media_req,
	input var fdc_media_pkg::media_rsp_t media_rsp,
	input var fdc_media_pkg::buf_fill_t buf_fill
);
	import fdc_reg_pkg::*;
	import fdc_media_pkg::*;

	head_cmd_t head_cmd;
	logic [7:0] head_position;
	logic head_track0;
	logic [BUF_AW-1:0] buf_rd_addr;
	logic [7:0] buf_rd_data;

	fdc_core u_core (
		.clk(clk),
		.reset_n(reset_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.irq(irq),
		.drq(drq),
		.media_req(media_req),
		.media_rsp(media_rsp),
		.head_cmd(head_cmd),
		.head_position(head_position),
		.head_track0(head_track0),
		.buf_rd_addr(buf_rd_addr),
		.buf_rd_data(buf_rd_data)
	);

	head_positioner u_head (
		.clk(clk),
		.reset_n(reset_n),
		.head_cmd(head_cmd),
		.position(head_position),
		.track0(head_track0)
	);

	// filled by the workhorse, drained through the data register
	sector_buffer u_buf (
		.clk(clk),
		.fill(buf_fill),
		.rd_addr(buf_rd_addr),
		.rd_data(buf_rd_data)
	);

endmodule

`default_nettype wire

// ==== verification/fdc_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fdc_tb;
	import fdc_reg_pkg::*;
	import fdc_media_pkg::*;

	localparam int unsigned CLK_PERIOD = 40;
	localparam int unsigned MEDIA_DELAY = 10; // workhorse think time before the fill
	// twice four sectors of reads at up to five cycles each
	localparam int unsigned WATCHDOG_NS = 2 * 4 * SECTOR_SIZE * 5 * CLK_PERIOD;

	logic clk;
	logic reset_n;
	logic psel;
	logic penable;
	logic pwrite;
	reg_addr_e paddr;
	logic [7:0] pwdata;
	logic [7:0] prdata;
	logic pready;
	logic irq;
	logic drq;
	media_req_t media_req;
	media_rsp_t media_rsp;
	buf_fill_t buf_fill;

	logic media_fail;
	logic [31:0] lcg_state;
	logic [7:0] sector_bytes [SECTOR_SIZE]; // workhorse copy of the last sector
	media_req_t req_log [$];

	fdc_top dut_i (
		.clk(clk),
		.reset_n(reset_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.irq(irq),
		.drq(drq),
		.media_req(media_req),
		.media_rsp(media_rsp),
		.buf_fill(buf_fill)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else
			fail_now($sformatf("** Error at %0d ns: %s is 0x%02h, expected 0x%02h",
				$time, what, got, exp));
	endtask

	task automatic apb_write(input reg_addr_e addr, input logic [7:0] data);
		int waits;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		waits = 0;
		#1;
		while (!pready) begin
			if (waits == 4)
				fail_now("APB write never completed, pready stayed low");
			@(negedge clk);
			#1;
			waits++;
		end
		@(negedge clk); // access edge has passed
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_read(input reg_addr_e addr, output logic [7:0] data, output int waits);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		waits = 0;
		#1;
		while (!pready) begin
			if (waits == 4)
				fail_now("APB read never completed, pready stayed low");
			@(negedge clk);
			#1;
			waits++;
		end
		data = prdata;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic read_expect(input reg_addr_e addr, input logic [7:0] exp, input string what);
		logic [7:0] d;
		int w;
		apb_read(addr, d, w);
		check_value(what, d, exp);
	endtask

	// waits for drq when want_drq is set and for irq otherwise
	task automatic wait_flag(input bit want_drq, input int max_cycles);
		int n;
		n = 0;
		while ((want_drq ? drq : irq) !== 1'b1) begin
			if (n == max_cycles)
				fail_now(want_drq ? "timed out waiting for drq" : "timed out waiting for irq");
			@(negedge clk);
			n++;
		end
	endtask

	task automatic drain_sector();
		logic [7:0] d;
		int w;
		int i;
		for (i = 0; i < SECTOR_SIZE; i++) begin
			apb_read(REG_DATA, d, w);
			check_value($sformatf("data byte %0d", i), d, sector_bytes[i]);
			check_value("data read wait states", 8'(w), 8'd1);
		end
	endtask

	task automatic run_type1(input logic [7:0] cmd, input logic [7:0] exp_stat,
			input logic [7:0] exp_track);
		apb_write(REG_CMD, cmd);
		wait_flag(1'b0, 8);
		read_expect(REG_CMD, exp_stat, "type I status");
		check_value("irq after status read", {7'b0, irq}, 8'd0);
		read_expect(REG_TRACK, exp_track, "track register");
	endtask

	task automatic register_access();
		read_expect(REG_CMD, 8'h00, "status after reset");
		apb_write(REG_TRACK, 8'h5a);
		apb_write(REG_SECTOR, 8'h03);
		read_expect(REG_TRACK, 8'h5a, "track register");
		read_expect(REG_SECTOR, 8'h03, "sector register");
	endtask

	task automatic head_commands();
		run_type1(8'h08, 8'h26, 8'd0); // restore with head load
		apb_write(REG_TRACK, 8'd5);
		run_type1(8'h10, 8'h02, 8'd5); // seek
		run_type1(8'h50, 8'h02, 8'd6); // step in with update
		run_type1(8'h20, 8'h02, 8'd6); // plain step moves the head to 7
		run_type1(8'h70, 8'h02, 8'd6); // back out to 6
	endtask

	task automatic single_sector_read();
		logic [7:0] d;
		int w;
		apb_write(REG_TRACK, 8'h21);
		apb_write(REG_SECTOR, 8'd3);
		req_log.delete();
		apb_write(REG_CMD, 8'h88); // side 1
		check_value("req valid", {7'b0, media_req.valid}, 8'd1);
		check_value("req track", media_req.track, 8'h21);
		check_value("req sector", media_req.sector, 8'd3);
		check_value("req side", {7'b0, media_req.side}, 8'd1);
		wait_flag(1'b1, 1000);
		check_value("irq while drq", {7'b0, irq}, 8'd0);
		read_expect(REG_CMD, 8'h03, "status with data ready");
		drain_sector();
		check_value("drq after sector", {7'b0, drq}, 8'd0);
		check_value("irq after sector", {7'b0, irq}, 8'd1);
		read_expect(REG_CMD, 8'h00, "status after sector");
		apb_read(REG_DATA, d, w);
		check_value("data read past end", d, 8'h00);
		check_value("empty data read wait states", 8'(w), 8'd0);
		check_value("request count", 8'(req_log.size()), 8'd1);
	endtask

	task automatic multi_sector_read();
		apb_write(REG_SECTOR, 8'd9);
		req_log.delete();
		apb_write(REG_CMD, 8'h90);
		wait_flag(1'b1, 1000);
		drain_sector();
		check_value("irq between sectors", {7'b0, irq}, 8'd0);
		check_value("drq between sectors", {7'b0, drq}, 8'd0);
		read_expect(REG_CMD, 8'h01, "status between sectors");
		wait_flag(1'b1, 1000);
		drain_sector();
		check_value("irq at end of track", {7'b0, irq}, 8'd1);
		check_value("drq at end of track", {7'b0, drq}, 8'd0);
		check_value("request count", 8'(req_log.size()), 8'd2);
		check_value("first req sector", req_log[0].sector, 8'd9);
		check_value("second req sector", req_log[1].sector, 8'd10);
		read_expect(REG_SECTOR, 8'd10, "final sector register");
		read_expect(REG_CMD, 8'h00, "status after multi read");
	endtask

	task automatic read_error_and_busy();
		media_fail = 1'b1;
		apb_write(REG_SECTOR, 8'd4);
		apb_write(REG_CMD, 8'h80);
		read_expect(REG_CMD, 8'h01, "status while pending");
		apb_write(REG_TRACK, 8'h44); // dropped while busy
		wait_flag(1'b0, 1000);
		check_value("drq after error", {7'b0, drq}, 8'd0);
		read_expect(REG_CMD, 8'h10, "status after error");
		check_value("irq after status read", {7'b0, irq}, 8'd0);
		read_expect(REG_TRACK, 8'h21, "track after busy write");
		media_fail = 1'b0;
	endtask

	// workhorse model answering each request with a fresh pseudo-random sector
	always begin : workhorse
		int i;
		@(negedge clk);
		if (media_req.valid) begin
			req_log.push_back(media_req);
			repeat (MEDIA_DELAY) @(negedge clk);
			if (!media_fail) begin
				for (i = 0; i < SECTOR_SIZE; i++) begin
					lcg_state = lcg_next(lcg_state);
					sector_bytes[i] = lcg_state[23:16];
					buf_fill = '{we: 1'b1, addr: BUF_AW'(i), data: lcg_state[23:16]};
					@(negedge clk);
				end
				buf_fill.we = 1'b0;
			end
			media_rsp = '{done: 1'b1, ok: !media_fail};
			@(negedge clk);
			media_rsp = '{done: 1'b0, ok: 1'b0};
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		fail_now("watchdog expired, the tests did not finish in time");
	end

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = REG_CMD;
		pwdata = 8'h00;
		media_rsp = '0;
		buf_fill = '0;
		media_fail = 1'b0;
		lcg_state = 32'd36394;
		repeat (2) @(negedge clk);
		reset_n = 1'b1;
		register_access();
		head_commands();
		single_sector_read();
		multi_sector_read();
		read_error_and_busy();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fdc_top.f ====
hdl/fdc_reg_pkg.sv
hdl/fdc_media_pkg.sv
hdl/head_positioner.sv
hdl/sector_buffer.sv
hdl/fdc_core.sv
hdl/fdc_top.sv
verification/fdc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module fdc_tb -f fdc_top.f -o fdc_sim || exit 1
./obj_dir/fdc_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0
